/* Makefile */
# Verilator build and run of the key-value database subsystem testbench

LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing -f db_subsystem.f --top-module db_subsystem_tb \
		-o db_subsystem_sim
	./obj_dir/db_subsystem_sim | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f db_subsystem.f --top-module db_subsystem

clean:
	rm -rf obj_dir $(LOG)

/* db_subsystem.f */
+incdir+source
+incdir+test
source/db_pkg.sv
source/db_ctrl_prio_mux.sv
source/db_peripheral.sv
source/db_store_array.sv
source/db_subsystem.sv
test/db_subsystem_tb.sv

/* source/db_ctrl_prio_mux.sv */
`timescale 1ns/1ps

module db_ctrl_prio_mux
    import db_pkg::*;
(
    input  logic     clk,
    input  logic     srst,

    // High-priority controller
    input  logic     hi_req,
    input  command_t hi_command,
    input  key_t     hi_key,
    input  value_t   hi_set_value,
    output logic     hi_rdy,
    output logic     hi_ack,
    output status_t  hi_status,
    output logic     hi_get_valid,
    output value_t   hi_get_value,

    // Low-priority controller
    input  logic     lo_req,
    input  command_t lo_command,
    input  key_t     lo_key,
    input  value_t   lo_set_value,
    output logic     lo_rdy,
    output logic     lo_ack,
    output status_t  lo_status,
    output logic     lo_get_valid,
    output value_t   lo_get_value,

    // Shared peripheral
    output logic     per_req,
    output command_t per_command,
    output key_t     per_key,
    output value_t   per_set_value,
    input  logic     per_rdy,
    input  logic     per_ack,
    input  status_t  per_status,
    input  logic     per_get_valid,
    input  value_t   per_get_value
);

    // ======================================================================
    // Arbitration state
    // ======================================================================

    logic locked;
    logic owner_hi;
    logic sel_hi;
    logic accept;

    // Owner holds the path from acceptance to ack
    assign sel_hi = locked ? owner_hi : hi_req;
    assign accept = per_req && per_rdy;

    always_ff @(posedge clk) begin
        if (srst) begin
            locked   <= 1'b0;
            owner_hi <= 1'b0;
        end else if (per_ack) begin
            locked <= 1'b0;
        end else if (accept) begin
            locked   <= 1'b1;
            owner_hi <= sel_hi;
        end
    end

    // ======================================================================
    // Request path
    // ======================================================================

    assign per_req       = sel_hi ? hi_req       : lo_req;
    assign per_command   = sel_hi ? hi_command   : lo_command;
    assign per_key       = sel_hi ? hi_key       : lo_key;
    assign per_set_value = sel_hi ? hi_set_value : lo_set_value;

    // Ready only toward the selected side
    assign hi_rdy = per_rdy && sel_hi;
    assign lo_rdy = per_rdy && !sel_hi;

    // ======================================================================
    // Response path
    // ======================================================================

    // Ack goes back to the recorded owner only
    assign hi_ack = per_ack && locked && owner_hi;
    assign lo_ack = per_ack && locked && !owner_hi;

    // Response fields are qualified by ack on each side
    assign hi_status    = per_status;
    assign hi_get_valid = per_get_valid;
    assign hi_get_value = per_get_value;

    assign lo_status    = per_status;
    assign lo_get_valid = per_get_valid;
    assign lo_get_value = per_get_value;

endmodule : db_ctrl_prio_mux

/* source/db_peripheral.sv */
`timescale 1ns/1ps

module db_peripheral
    import db_pkg::*;
(
    input  logic     clk,
    input  logic     srst,

    // Controller side
    input  logic     req,
    input  command_t command,
    input  key_t     key,
    input  value_t   set_value,
    output logic     rdy,
    output logic     ack,
    output status_t  status,
    output logic     get_valid,
    output value_t   get_value,

    // Store read channel
    output logic     rd_req,
    output key_t     rd_key,
    input  logic     rd_rdy,
    input  logic     rd_ack,
    input  logic     rd_valid,
    input  value_t   rd_value,

    // Store write channel
    output logic     wr_req,
    output key_t     wr_key,
    output logic     wr_valid,
    output value_t   wr_value,
    input  logic     wr_rdy,
    input  logic     wr_ack,

    // Store clear
    output logic     clear_req,
    input  logic     init_done
);

    typedef enum logic [2:0] {
        IDLE,
        RD,
        WR,
        CLEAR_WAIT,
        RESPOND
    } state_t;

    state_t   state;
    logic     issued;
    logic     accept;

    command_t command_r;
    key_t     key_r;
    value_t   set_value_r;
    status_t  status_r;
    logic     get_valid_r;
    value_t   get_value_r;

    assign rdy    = (state == IDLE) && init_done;
    assign accept = req && rdy;

    // ======================================================================
    // Command sequencer
    // ======================================================================

    always_ff @(posedge clk) begin
        if (srst) begin
            state  <= IDLE;
            issued <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        case (command)
                            COMMAND_GET:   state <= RD;
                            COMMAND_SET:   state <= WR;
                            COMMAND_UNSET: state <= WR;
                            COMMAND_CLEAR: state <= CLEAR_WAIT;
                            // NOP and illegal codes answer directly
                            default:       state <= RESPOND;
                        endcase
                    end
                end
                RD: begin
                    if (rd_req && rd_rdy) begin
                        issued <= 1'b1;
                    end
                    if (rd_ack) begin
                        issued <= 1'b0;
                        state  <= RESPOND;
                    end
                end
                WR: begin
                    if (wr_req && wr_rdy) begin
                        issued <= 1'b1;
                    end
                    if (wr_ack) begin
                        issued <= 1'b0;
                        state  <= RESPOND;
                    end
                end
                CLEAR_WAIT: begin
                    // init_done is already low in the cycle after the pulse
                    if (!issued) begin
                        issued <= 1'b1;
                    end else if (init_done) begin
                        issued <= 1'b0;
                        state  <= RESPOND;
                    end
                end
                RESPOND: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ======================================================================
    // Command and response registers
    // ======================================================================

    always_ff @(posedge clk) begin
        if (accept) begin
            command_r   <= command;
            key_r       <= key;
            set_value_r <= set_value;
            get_valid_r <= 1'b0;
            case (command)
                COMMAND_NOP,
                COMMAND_GET,
                COMMAND_SET,
                COMMAND_UNSET,
                COMMAND_CLEAR: status_r <= STATUS_OK;
                default:       status_r <= STATUS_ERROR;
            endcase
        end
        if (state == RD && rd_ack) begin
            get_valid_r <= rd_valid;
            get_value_r <= rd_value;
        end
    end

    // One store request per command
    assign rd_req    = (state == RD) && !issued;
    assign wr_req    = (state == WR) && !issued;
    assign clear_req = (state == CLEAR_WAIT) && !issued;

    assign rd_key   = key_r;
    assign wr_key   = key_r;
    assign wr_valid = (command_r == COMMAND_SET);
    assign wr_value = set_value_r;

    assign ack       = (state == RESPOND);
    assign status    = status_r;
    assign get_valid = get_valid_r;
    assign get_value = get_value_r;

endmodule : db_peripheral

/* source/db_pkg.sv */
`include "db_settings.svh"

package db_pkg;

    // ======================================================================
    // Payload types
    // ======================================================================

    // Key into the store, one entry per key
    typedef logic [`DB_KEY_WID-1:0] key_t;

    // Value held by one entry
    typedef logic [`DB_VALUE_WID-1:0] value_t;

    // ======================================================================
    // Control port encodings
    // ======================================================================

    // Controller commands
    // Codes 5 to 7 are not assigned and are answered with an error
    typedef enum logic [2:0] {
        COMMAND_NOP   = 3'd0,
        COMMAND_GET   = 3'd1,
        COMMAND_SET   = 3'd2,
        COMMAND_UNSET = 3'd3,
        COMMAND_CLEAR = 3'd4
    } command_t;

    // Completion status returned with ack
    typedef enum logic [1:0] {
        STATUS_OK    = 2'd0,
        STATUS_ERROR = 2'd1
    } status_t;

endpackage : db_pkg

/* source/db_settings.svh */
`ifndef DB_SETTINGS_SVH
`define DB_SETTINGS_SVH

// ==========================================================================
// Database sizing
// ==========================================================================

// Key width sets the number of store entries (2**DB_KEY_WID)
`define DB_KEY_WID 8

// Width of one stored value
`define DB_VALUE_WID 32

`endif

/* source/db_store_array.sv */
`timescale 1ns/1ps

module db_store_array
    import db_pkg::*;
(
    input  logic   clk,
    input  logic   srst,

    // Read channel
    input  logic   rd_req,
    input  key_t   rd_key,
    output logic   rd_rdy,
    output logic   rd_ack,
    output logic   rd_valid,
    output value_t rd_value,

    // Write channel
    input  logic   wr_req,
    input  key_t   wr_key,
    input  logic   wr_valid,
    input  value_t wr_value,
    output logic   wr_rdy,
    output logic   wr_ack,

    // Clear
    input  logic   clear_req,
    output logic   init_done
);

    localparam int SIZE = 2**$bits(key_t);

    value_t          value_mem [SIZE];
    logic [SIZE-1:0] valid_bits;

    logic sweeping;
    key_t sweep_addr;
    logic rd_accept;
    logic wr_accept;

    assign rd_rdy    = !sweeping;
    assign wr_rdy    = !sweeping;
    assign rd_accept = rd_req && rd_rdy;
    assign wr_accept = wr_req && wr_rdy;

    // ======================================================================
    // Clear sweep
    // ======================================================================

    // Walks every address once, after reset and on request
    always_ff @(posedge clk) begin
        if (srst) begin
            sweeping   <= 1'b1;
            sweep_addr <= '0;
            init_done  <= 1'b0;
        end else if (sweeping) begin
            sweep_addr <= sweep_addr + 1'b1;
            if (sweep_addr == key_t'(SIZE - 1)) begin
                sweeping  <= 1'b0;
                init_done <= 1'b1;
            end
        end else if (clear_req) begin
            sweeping   <= 1'b1;
            sweep_addr <= '0;
            init_done  <= 1'b0;
        end
    end

    // ======================================================================
    // Storage
    // ======================================================================

    always_ff @(posedge clk) begin
        if (sweeping) begin
            valid_bits[sweep_addr] <= 1'b0;
        end else if (wr_accept) begin
            valid_bits[wr_key] <= wr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            value_mem[wr_key] <= wr_value;
        end
    end

    // Read data registered on acceptance
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rd_valid <= valid_bits[rd_key];
            rd_value <= value_mem[rd_key];
        end
    end

    // Acks one cycle after acceptance
    always_ff @(posedge clk) begin
        if (srst) begin
            rd_ack <= 1'b0;
            wr_ack <= 1'b0;
        end else begin
            rd_ack <= rd_accept;
            wr_ack <= wr_accept;
        end
    end

endmodule : db_store_array

/* source/db_subsystem.sv */
`timescale 1ns/1ps

module db_subsystem
    import db_pkg::*;
(
    input  logic     clk,
    input  logic     srst,

    // High-priority controller
    input  logic     hi_req,
    input  command_t hi_command,
    input  key_t     hi_key,
    input  value_t   hi_set_value,
    output logic     hi_rdy,
    output logic     hi_ack,
    output status_t  hi_status,
    output logic     hi_get_valid,
    output value_t   hi_get_value,

    // Low-priority controller
    input  logic     lo_req,
    input  command_t lo_command,
    input  key_t     lo_key,
    input  value_t   lo_set_value,
    output logic     lo_rdy,
    output logic     lo_ack,
    output status_t  lo_status,
    output logic     lo_get_valid,
    output value_t   lo_get_value,

    output logic     init_done
);

    // Mux to peripheral
    logic     per_req;
    command_t per_command;
    key_t     per_key;
    value_t   per_set_value;
    logic     per_rdy;
    logic     per_ack;
    status_t  per_status;
    logic     per_get_valid;
    value_t   per_get_value;

    // Peripheral to store
    logic     rd_req;
    key_t     rd_key;
    logic     rd_rdy;
    logic     rd_ack;
    logic     rd_valid;
    value_t   rd_value;
    logic     wr_req;
    key_t     wr_key;
    logic     wr_valid;
    value_t   wr_value;
    logic     wr_rdy;
    logic     wr_ack;
    logic     clear_req;

    db_ctrl_prio_mux mux_i (
        .clk           ( clk ),
        .srst          ( srst ),
        .hi_req        ( hi_req ),
        .hi_command    ( hi_command ),
        .hi_key        ( hi_key ),
        .hi_set_value  ( hi_set_value ),
        .hi_rdy        ( hi_rdy ),
        .hi_ack        ( hi_ack ),
        .hi_status     ( hi_status ),
        .hi_get_valid  ( hi_get_valid ),
        .hi_get_value  ( hi_get_value ),
        .lo_req        ( lo_req ),
        .lo_command    ( lo_command ),
        .lo_key        ( lo_key ),
        .lo_set_value  ( lo_set_value ),
        .lo_rdy        ( lo_rdy ),
        .lo_ack        ( lo_ack ),
        .lo_status     ( lo_status ),
        .lo_get_valid  ( lo_get_valid ),
        .lo_get_value  ( lo_get_value ),
        .per_req       ( per_req ),
        .per_command   ( per_command ),
        .per_key       ( per_key ),
        .per_set_value ( per_set_value ),
        .per_rdy       ( per_rdy ),
        .per_ack       ( per_ack ),
        .per_status    ( per_status ),
        .per_get_valid ( per_get_valid ),
        .per_get_value ( per_get_value )
    );

    db_peripheral peripheral_i (
        .clk       ( clk ),
        .srst      ( srst ),
        .req       ( per_req ),
        .command   ( per_command ),
        .key       ( per_key ),
        .set_value ( per_set_value ),
        .rdy       ( per_rdy ),
        .ack       ( per_ack ),
        .status    ( per_status ),
        .get_valid ( per_get_valid ),
        .get_value ( per_get_value ),
        .rd_req    ( rd_req ),
        .rd_key    ( rd_key ),
        .rd_rdy    ( rd_rdy ),
        .rd_ack    ( rd_ack ),
        .rd_valid  ( rd_valid ),
        .rd_value  ( rd_value ),
        .wr_req    ( wr_req ),
        .wr_key    ( wr_key ),
        .wr_valid  ( wr_valid ),
        .wr_value  ( wr_value ),
        .wr_rdy    ( wr_rdy ),
        .wr_ack    ( wr_ack ),
        .clear_req ( clear_req ),
        .init_done ( init_done )
    );

    db_store_array store_i (
        .clk       ( clk ),
        .srst      ( srst ),
        .rd_req    ( rd_req ),
        .rd_key    ( rd_key ),
        .rd_rdy    ( rd_rdy ),
        .rd_ack    ( rd_ack ),
        .rd_valid  ( rd_valid ),
        .rd_value  ( rd_value ),
        .wr_req    ( wr_req ),
        .wr_key    ( wr_key ),
        .wr_valid  ( wr_valid ),
        .wr_value  ( wr_value ),
        .wr_rdy    ( wr_rdy ),
        .wr_ack    ( wr_ack ),
        .clear_req ( clear_req ),
        .init_done ( init_done )
    );

endmodule : db_subsystem

/* test/db_subsystem_tasks.svh */
`ifndef DB_SUBSYSTEM_TASKS_SVH
`define DB_SUBSYSTEM_TASKS_SVH

    // ======================================================================
    // Bookkeeping and compares
    // ======================================================================

    function automatic key_t rand_key();
        return key_t'($random(seed));
    endfunction

    function automatic value_t rand_value();
        return value_t'($random(seed));
    endfunction

    function automatic string port_field(input logic use_hi, input string field);
        return $sformatf("%s_%s", use_hi ? "hi" : "lo", field);
    endfunction

    task automatic note_failure(input string what);
        $display("error at %0t: %s", $time, what);
        error_count++;
    endtask

    task automatic end_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic compare_status(input string name, input status_t got, input status_t exp);
        check_count++;
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %s expected %s",
                     $time, name, got.name(), exp.name());
            error_count++;
        end
    endtask

    task automatic compare_valid(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_value(input string name, input value_t got, input value_t exp);
        check_count++;
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    // ======================================================================
    // Controller driver
    // ======================================================================

    // One command on one port from request to ack
    task automatic send_cmd(
        input  logic     use_hi,
        input  command_t command,
        input  key_t     key,
        input  value_t   value,
        output status_t  status,
        output logic     get_valid,
        output value_t   get_value,
        output time      accept_time,
        output time      ack_time
    );
        int   cycles;
        logic seen;
        status      = STATUS_ERROR;
        get_valid   = 1'b0;
        get_value   = '0;
        accept_time = 0;
        ack_time    = 0;
        @(posedge clk);
        if (use_hi) begin
            hi_req       <= 1'b1;
            hi_command   <= command;
            hi_key       <= key;
            hi_set_value <= value;
        end else begin
            lo_req       <= 1'b1;
            lo_command   <= command;
            lo_key       <= key;
            lo_set_value <= value;
        end
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < RDY_TIMEOUT) begin
            @(negedge clk);
            seen = use_hi ? hi_rdy : lo_rdy;
            cycles++;
        end
        // Accepted on this edge when rdy was seen
        @(posedge clk);
        accept_time = $time;
        if (use_hi) begin
            hi_req <= 1'b0;
        end else begin
            lo_req <= 1'b0;
        end
        if (!seen) begin
            note_failure($sformatf("%s never went high", port_field(use_hi, "rdy")));
            return;
        end
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            seen = use_hi ? hi_ack : lo_ack;
            cycles++;
        end
        if (!seen) begin
            note_failure($sformatf("no %s after the command was accepted",
                                   port_field(use_hi, "ack")));
            return;
        end
        ack_time  = $time;
        status    = use_hi ? hi_status : lo_status;
        get_valid = use_hi ? hi_get_valid : lo_get_valid;
        get_value = use_hi ? hi_get_value : lo_get_value;
    endtask

    // GET result against the model
    task automatic check_get(input logic use_hi, input key_t key, input status_t status,
                             input logic get_valid, input value_t get_value);
        logic exp_valid;
        exp_valid = model_value.exists(key) != 0;
        compare_status(port_field(use_hi, "status"), status, STATUS_OK);
        compare_valid(port_field(use_hi, "get_valid"), get_valid, exp_valid);
        if (exp_valid) begin
            compare_value(port_field(use_hi, "get_value"), get_value, model_value[key]);
        end
    endtask

    task automatic expect_get(input logic use_hi, input key_t key);
        status_t st;
        logic    gv;
        value_t  gval;
        time     t_acc;
        time     t_ack;
        send_cmd(use_hi, COMMAND_GET, key, '0, st, gv, gval, t_acc, t_ack);
        check_get(use_hi, key, st, gv, gval);
    endtask

    // NOP, CLEAR and illegal codes only carry a status
    task automatic run_plain(input logic use_hi, input command_t command, input key_t key,
                             input value_t value, input status_t exp);
        status_t st;
        logic    gv;
        value_t  gval;
        time     t_acc;
        time     t_ack;
        send_cmd(use_hi, command, key, value, st, gv, gval, t_acc, t_ack);
        compare_status(port_field(use_hi, "status"), st, exp);
    endtask

    task automatic run_set(input logic use_hi, input key_t key, input value_t value);
        status_t st;
        logic    gv;
        value_t  gval;
        time     t_acc;
        time     t_ack;
        send_cmd(use_hi, COMMAND_SET, key, value, st, gv, gval, t_acc, t_ack);
        compare_status(port_field(use_hi, "status"), st, STATUS_OK);
        model_value[key] = value;
        written_keys.push_back(key);
    endtask

    task automatic run_unset(input logic use_hi, input key_t key);
        status_t st;
        logic    gv;
        value_t  gval;
        time     t_acc;
        time     t_ack;
        send_cmd(use_hi, COMMAND_UNSET, key, '0, st, gv, gval, t_acc, t_ack);
        compare_status(port_field(use_hi, "status"), st, STATUS_OK);
        model_value.delete(key);
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================

    task automatic test_reset_init();
        int errors_before;
        int cycles;
        errors_before = error_count;
        cycles = 0;
        // lo requests from the start of the sweep and hi joins halfway
        fork
            begin
                while (!init_done && cycles < INIT_TIMEOUT) begin
                    @(negedge clk);
                    if (!init_done && (hi_rdy || lo_rdy)) begin
                        note_failure("a controller saw rdy before init_done");
                    end
                    cycles++;
                end
            end
            expect_get(1'b0, key_t'(NUM_KEYS - 1));
            begin
                repeat (NUM_KEYS / 2) @(posedge clk);
                expect_get(1'b1, '0);
            end
        join
        if (!init_done) begin
            note_failure("init_done did not rise after reset");
        end
        expect_get(1'b1, rand_key());
        end_test("reset_init", errors_before);
    endtask

    task automatic test_set_get();
        int     errors_before;
        key_t   key;
        value_t value;
        errors_before = error_count;
        for (int i = 0; i < 8; i++) begin
            key   = rand_key();
            value = rand_value();
            run_set(i[0], key, value);
            expect_get(!i[0], key);
        end
        foreach (written_keys[i]) begin
            expect_get(1'b1, written_keys[i]);
        end
        end_test("set_get", errors_before);
    endtask

    task automatic test_unset();
        int errors_before;
        errors_before = error_count;
        run_unset(1'b0, written_keys[0]);
        expect_get(1'b1, written_keys[0]);
        // Remaining keys keep their values
        foreach (written_keys[i]) begin
            expect_get(1'b0, written_keys[i]);
        end
        end_test("unset", errors_before);
    endtask

    task automatic test_priority();
        int      errors_before;
        key_t    key;
        value_t  value;
        status_t hi_st;
        status_t lo_st;
        logic    hi_gv;
        logic    lo_gv;
        value_t  hi_gval;
        value_t  lo_gval;
        time     hi_acc;
        time     hi_ack_t;
        time     lo_acc;
        time     lo_ack_t;
        errors_before = error_count;

        // The lo GET of a same-cycle request pair must see the hi SET
        key   = rand_key();
        value = rand_value();
        fork
            send_cmd(1'b1, COMMAND_SET, key, value, hi_st, hi_gv, hi_gval, hi_acc, hi_ack_t);
            send_cmd(1'b0, COMMAND_GET, key, '0, lo_st, lo_gv, lo_gval, lo_acc, lo_ack_t);
        join
        if (!(hi_ack_t < lo_acc)) begin
            note_failure("lo was accepted before hi was acknowledged");
        end
        compare_status("hi_status", hi_st, STATUS_OK);
        model_value[key] = value;
        written_keys.push_back(key);
        check_get(1'b0, key, lo_st, lo_gv, lo_gval);

        // A later hi request waits for lo_ack while lo holds the lock
        key   = rand_key();
        value = rand_value();
        fork
            send_cmd(1'b0, COMMAND_SET, key, value, lo_st, lo_gv, lo_gval, lo_acc, lo_ack_t);
            begin
                repeat (2) @(posedge clk);
                send_cmd(1'b1, COMMAND_GET, key, '0, hi_st, hi_gv, hi_gval, hi_acc, hi_ack_t);
            end
        join
        if (!(hi_acc > lo_ack_t)) begin
            note_failure("hi was accepted while lo still held the lock");
        end
        compare_status("lo_status", lo_st, STATUS_OK);
        model_value[key] = value;
        written_keys.push_back(key);
        check_get(1'b1, key, hi_st, hi_gv, hi_gval);
        end_test("priority", errors_before);
    endtask

    task automatic test_clear();
        int errors_before;
        errors_before = error_count;
        run_plain(1'b1, COMMAND_CLEAR, '0, '0, STATUS_OK);
        model_value.delete();
        foreach (written_keys[i]) begin
            expect_get(i[0], written_keys[i]);
        end
        written_keys.delete();
        end_test("clear", errors_before);
    endtask

    task automatic test_nop_illegal();
        int     errors_before;
        key_t   key;
        value_t value;
        errors_before = error_count;
        key   = rand_key();
        value = rand_value();
        run_set(1'b0, key, value);
        // Same key with another value, so any stray write would show
        run_plain(1'b1, COMMAND_NOP, key, ~value, STATUS_OK);
        run_plain(1'b0, command_t'(3'd6), key, ~value, STATUS_ERROR);
        run_plain(1'b1, command_t'(3'd7), key, ~value, STATUS_ERROR);
        // Store untouched by the commands above
        expect_get(1'b1, key);
        expect_get(1'b0, key);
        end_test("nop_illegal", errors_before);
    endtask

`endif

/* test/db_subsystem_tb.sv */
`timescale 1ns/1ps

`include "db_settings.svh"

module db_subsystem_tb
    import db_pkg::*;
();

    // ======================================================================
    // Limits and DUT signals
    // ======================================================================

    localparam int NUM_KEYS     = 2**`DB_KEY_WID;
    localparam int INIT_TIMEOUT = 2 * NUM_KEYS + 100;
    localparam int RDY_TIMEOUT  = 4 * NUM_KEYS;
    localparam int ACK_TIMEOUT  = 4 * NUM_KEYS;

    logic     clk;
    logic     srst;

    logic     hi_req;
    command_t hi_command;
    key_t     hi_key;
    value_t   hi_set_value;
    logic     hi_rdy;
    logic     hi_ack;
    status_t  hi_status;
    logic     hi_get_valid;
    value_t   hi_get_value;

    logic     lo_req;
    command_t lo_command;
    key_t     lo_key;
    value_t   lo_set_value;
    logic     lo_rdy;
    logic     lo_ack;
    status_t  lo_status;
    logic     lo_get_valid;
    value_t   lo_get_value;

    logic     init_done;

    // Reference model where a key is valid while it has an entry
    value_t model_value [key_t];
    key_t   written_keys [$];

    integer seed = 32'hdd4c_9e69;
    int     error_count = 0;
    int     check_count = 0;
    int     test_count  = 0;

    db_subsystem dut_i (
        .clk          ( clk ),
        .srst         ( srst ),
        .hi_req       ( hi_req ),
        .hi_command   ( hi_command ),
        .hi_key       ( hi_key ),
        .hi_set_value ( hi_set_value ),
        .hi_rdy       ( hi_rdy ),
        .hi_ack       ( hi_ack ),
        .hi_status    ( hi_status ),
        .hi_get_valid ( hi_get_valid ),
        .hi_get_value ( hi_get_value ),
        .lo_req       ( lo_req ),
        .lo_command   ( lo_command ),
        .lo_key       ( lo_key ),
        .lo_set_value ( lo_set_value ),
        .lo_rdy       ( lo_rdy ),
        .lo_ack       ( lo_ack ),
        .lo_status    ( lo_status ),
        .lo_get_valid ( lo_get_valid ),
        .lo_get_value ( lo_get_value ),
        .init_done    ( init_done )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    `include "db_subsystem_tasks.svh"

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        srst         = 1'b1;
        hi_req       = 1'b0;
        hi_command   = COMMAND_NOP;
        hi_key       = '0;
        hi_set_value = '0;
        lo_req       = 1'b0;
        lo_command   = COMMAND_NOP;
        lo_key       = '0;
        lo_set_value = '0;

        repeat (5) @(posedge clk);
        srst <= 1'b0;

        test_reset_init();
        test_set_get();
        test_unset();
        test_priority();
        test_clear();
        test_nop_illegal();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : db_subsystem_tb
